//--- hw/cpu_pkg.sv
// shared word, register and opcode types plus memory sizes for the 16-bit pipelined cpu
`default_nettype none

package cpu_pkg;

    localparam int word_w      = 16;
    localparam int reg_w       = 4;
    localparam int reg_count   = 16;
    localparam int dmem_depth  = 256;
    localparam int dmem_addr_w = $clog2(dmem_depth);

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_w-1:0]  reg_idx_t;

    // opcode lives in instr[15:12]; codes 14 and 15 fall through as no-op
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_slt  = 4'd5,
        op_li   = 4'd6,
        op_lw   = 4'd7,
        op_sw   = 4'd8,
        op_bz   = 4'd9,
        op_jmp  = 4'd10,
        op_in   = 4'd11,
        op_out  = 4'd12,
        op_halt = 4'd13
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // add r0,r0,r0
    localparam word_t nop_word = '0;

endpackage

`default_nettype wire

//--- hw/cpu_stage_ifs.sv
// pipeline link interfaces between fetch, decode, execute and memory/writeback
`timescale 1ns/100ps
`default_nettype none

interface fetch_decode_if;
    logic           valid;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t instr;
    logic           flush;
    cpu_pkg::word_t redirect_pc;
    logic           freeze;

    modport source (output valid, pc, instr, input flush, redirect_pc, freeze);
    modport sink   (input valid, pc, instr, freeze);
endinterface

interface decode_execute_if;
    logic               valid;
    cpu_pkg::word_t     pc;
    cpu_pkg::opcode_e   opcode;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::reg_idx_t  rd;
    cpu_pkg::reg_idx_t  rs1;
    cpu_pkg::reg_idx_t  rs2;
    cpu_pkg::word_t     op_a;
    cpu_pkg::word_t     op_b;
    cpu_pkg::word_t     imm;
    logic               writes_reg;
    logic               is_load;
    logic               is_store;
    logic               is_branch;
    logic               is_jump;
    logic               is_out;
    logic               is_in;
    logic               is_halt;
    logic               flush;

    modport source (
        output valid, pc, opcode, alu_op, rd, rs1, rs2, op_a, op_b, imm,
        output writes_reg, is_load, is_store, is_branch, is_jump, is_out, is_in, is_halt,
        input  flush
    );
    modport sink (
        input  valid, pc, opcode, alu_op, rd, rs1, rs2, op_a, op_b, imm,
        input  writes_reg, is_load, is_store, is_branch, is_jump, is_out, is_in, is_halt,
        output flush
    );
endinterface

interface execute_mem_if;
    logic              valid;
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    alu_result;
    cpu_pkg::word_t    store_data;
    cpu_pkg::reg_idx_t rd;
    logic              writes_reg;
    logic              is_load;
    logic              is_store;
    logic              is_out;
    logic              is_in;
    logic              is_halt;
    // writeback bundle and halt freeze flow back from memory/writeback
    logic              wb_en;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;
    logic              freeze;

    modport source (
        output valid, pc, alu_result, store_data, rd,
        output writes_reg, is_load, is_store, is_out, is_in, is_halt,
        input  wb_en, wb_rd, wb_data, freeze
    );
    modport sink (
        input  valid, pc, alu_result, store_data, rd,
        input  writes_reg, is_load, is_store, is_out, is_in, is_halt,
        output wb_en, wb_rd, wb_data, freeze
    );
endinterface

`default_nettype wire

//--- hw/cpu_fetch.sv
// fetch stage: program counter, instruction request and the fetch/decode register
`timescale 1ns/100ps
`default_nettype none

module cpu_fetch (
    input  logic           clock,
    input  logic           rst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    fetch_decode_if.source fd
);

    cpu_pkg::word_t pc;

    // instruction port answers in the same cycle
    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc       <= '0;
            fd.valid <= 1'b0;
        end else if (!fd.freeze) begin
            if (fd.flush) begin
                pc       <= fd.redirect_pc;
                fd.valid <= 1'b0;
            end else begin
                pc       <= pc + cpu_pkg::word_t'(1);
                fd.valid <= 1'b1;
            end
        end
    end

    // squashed fetch turns into a bubble
    always_ff @(posedge clock) begin
        if (!fd.freeze) begin
            fd.pc    <= pc;
            fd.instr <= fd.flush ? cpu_pkg::nop_word : imem_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_decode.sv
// decode stage: field split, control flags, register file and decode/execute register
`timescale 1ns/100ps
`default_nettype none

module cpu_decode (
    input  logic              clock,
    input  logic              rst_n,
    fetch_decode_if.sink      fd,
    decode_execute_if.source  de,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data
);

    cpu_pkg::word_t    regs [cpu_pkg::reg_count];
    cpu_pkg::opcode_e  opcode;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rs1;
    cpu_pkg::reg_idx_t rs2;
    cpu_pkg::word_t    imm;
    logic              writes_reg;
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              is_jump;
    logic              is_out;
    logic              is_in;
    logic              is_halt;

    // r0 reads zero, a same-cycle writeback passes straight through
    function automatic cpu_pkg::word_t read_reg(cpu_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    assign opcode = cpu_pkg::opcode_e'(fd.instr[15:12]);
    assign rd     = fd.instr[11:8];
    // bz tests the register in the rd field
    assign rs1 = (opcode == cpu_pkg::op_bz) ? fd.instr[11:8] : fd.instr[7:4];
    // sw and out take their data register from the rd field
    assign rs2 = (opcode == cpu_pkg::op_sw || opcode == cpu_pkg::op_out) ?
                 fd.instr[11:8] : fd.instr[3:0];

    always_comb begin
        alu_op     = cpu_pkg::alu_add;
        imm        = {{8{fd.instr[7]}}, fd.instr[7:0]};
        writes_reg = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_branch  = 1'b0;
        is_jump    = 1'b0;
        is_out     = 1'b0;
        is_in      = 1'b0;
        is_halt    = 1'b0;
        case (opcode)
            cpu_pkg::op_add: writes_reg = 1'b1;
            cpu_pkg::op_sub: begin
                alu_op     = cpu_pkg::alu_sub;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_and: begin
                alu_op     = cpu_pkg::alu_and;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_or: begin
                alu_op     = cpu_pkg::alu_or;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_xor: begin
                alu_op     = cpu_pkg::alu_xor;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_slt: begin
                alu_op     = cpu_pkg::alu_slt;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_li: begin
                alu_op     = cpu_pkg::alu_pass_b;
                writes_reg = 1'b1;
            end
            // unsigned 4-bit offset for memory access
            cpu_pkg::op_lw: begin
                imm        = {12'b0, fd.instr[3:0]};
                writes_reg = 1'b1;
                is_load    = 1'b1;
            end
            cpu_pkg::op_sw: begin
                imm      = {12'b0, fd.instr[3:0]};
                is_store = 1'b1;
            end
            cpu_pkg::op_bz:  is_branch = 1'b1;
            cpu_pkg::op_jmp: is_jump = 1'b1;
            cpu_pkg::op_in: begin
                alu_op     = cpu_pkg::alu_pass_b;
                writes_reg = 1'b1;
                is_in      = 1'b1;
            end
            cpu_pkg::op_out: begin
                alu_op = cpu_pkg::alu_pass_b;
                is_out = 1'b1;
            end
            cpu_pkg::op_halt: is_halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            de.valid <= 1'b0;
        end else if (!fd.freeze) begin
            de.valid <= fd.valid && !de.flush;
        end
    end

    always_ff @(posedge clock) begin
        if (!fd.freeze) begin
            de.pc         <= fd.pc;
            de.opcode     <= opcode;
            de.alu_op     <= alu_op;
            de.rd         <= rd;
            de.rs1        <= rs1;
            de.rs2        <= rs2;
            de.op_a       <= read_reg(rs1);
            de.op_b       <= read_reg(rs2);
            de.imm        <= imm;
            de.writes_reg <= writes_reg;
            de.is_load    <= is_load;
            de.is_store   <= is_store;
            de.is_branch  <= is_branch;
            de.is_jump    <= is_jump;
            de.is_out     <= is_out;
            de.is_in      <= is_in;
            de.is_halt    <= is_halt;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_execute.sv
// execute stage: forwarding, ALU, branch resolution and the execute/memory register
`timescale 1ns/100ps
`default_nettype none

module cpu_execute (
    input  logic            clock,
    input  logic            rst_n,
    decode_execute_if.sink  de,
    execute_mem_if.source   em,
    output logic            fd_flush,
    output cpu_pkg::word_t  redirect_pc
);

    cpu_pkg::word_t fwd_a;
    cpu_pkg::word_t fwd_b;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_result;
    logic           fwd_hit_a;
    logic           fwd_hit_b;
    logic           taken;

    // memory/writeback result overrides a stale operand, load data included
    assign fwd_hit_a = em.wb_en && em.wb_rd != '0 && em.wb_rd == de.rs1;
    assign fwd_hit_b = em.wb_en && em.wb_rd != '0 && em.wb_rd == de.rs2;
    assign fwd_a     = fwd_hit_a ? em.wb_data : de.op_a;
    assign fwd_b     = fwd_hit_b ? em.wb_data : de.op_b;

    assign alu_b = (de.is_load || de.is_store || de.opcode == cpu_pkg::op_li) ?
                   de.imm : fwd_b;

    always_comb begin
        case (de.alu_op)
            cpu_pkg::alu_sub:    alu_result = fwd_a - alu_b;
            cpu_pkg::alu_and:    alu_result = fwd_a & alu_b;
            cpu_pkg::alu_or:     alu_result = fwd_a | alu_b;
            cpu_pkg::alu_xor:    alu_result = fwd_a ^ alu_b;
            cpu_pkg::alu_slt:    alu_result = cpu_pkg::word_t'($signed(fwd_a) < $signed(alu_b));
            cpu_pkg::alu_pass_b: alu_result = alu_b;
            default:             alu_result = fwd_a + alu_b;
        endcase
    end

    // taken branch kills the two younger instructions
    assign taken       = de.valid && (de.is_jump || (de.is_branch && fwd_a == '0));
    assign redirect_pc = de.pc + de.imm;
    assign fd_flush    = taken;
    assign de.flush    = taken;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            em.valid <= 1'b0;
        end else if (!em.freeze) begin
            em.valid <= de.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!em.freeze) begin
            em.pc         <= de.pc;
            em.alu_result <= alu_result;
            em.store_data <= fwd_b;
            em.rd         <= de.rd;
            em.writes_reg <= de.writes_reg;
            em.is_load    <= de.is_load;
            em.is_store   <= de.is_store;
            em.is_out     <= de.is_out;
            em.is_in      <= de.is_in;
            em.is_halt    <= de.is_halt;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_mem_wb.sv
// memory/writeback stage: data memory, io port, halt capture and register writeback
`timescale 1ns/100ps
`default_nettype none

module cpu_mem_wb (
    input  logic           clock,
    input  logic           rst_n,
    execute_mem_if.sink    em,
    input  cpu_pkg::word_t io_in,
    output cpu_pkg::word_t io_out,
    output logic           io_out_valid,
    output logic           halted,
    output cpu_pkg::word_t halt_pc
);

    cpu_pkg::word_t                  dmem [cpu_pkg::dmem_depth];
    logic [cpu_pkg::dmem_addr_w-1:0] dmem_addr;
    cpu_pkg::word_t                  load_data;
    cpu_pkg::word_t                  out_reg;
    logic                            commit;

    // nothing commits once the halt has landed
    assign commit    = em.valid && !halted;
    assign dmem_addr = em.alu_result[cpu_pkg::dmem_addr_w-1:0];
    assign load_data = dmem[dmem_addr];

    always_ff @(posedge clock) begin
        if (commit && em.is_store) begin
            dmem[dmem_addr] <= em.store_data;
        end
    end

    assign em.wb_en   = commit && em.writes_reg;
    assign em.wb_rd   = em.rd;
    assign em.wb_data = em.is_load ? load_data : (em.is_in ? io_in : em.alu_result);
    assign em.freeze  = halted;

    // value shows in the commit cycle and is held afterwards
    assign io_out_valid = commit && em.is_out;
    assign io_out       = io_out_valid ? em.alu_result : out_reg;

    always_ff @(posedge clock) begin
        if (io_out_valid) begin
            out_reg <= em.alu_result;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            halted  <= 1'b0;
            halt_pc <= '0;
        end else if (commit && em.is_halt) begin
            halted  <= 1'b1;
            halt_pc <= em.pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
// top level of the pipelined cpu, joins the four stages behind plain external ports
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  logic           clock,
    input  logic           rst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    input  cpu_pkg::word_t io_in,
    output cpu_pkg::word_t io_out,
    output logic           io_out_valid,
    output logic           halted,
    output cpu_pkg::word_t halt_pc
);

    fetch_decode_if   fd_if ();
    decode_execute_if de_if ();
    execute_mem_if    em_if ();

    logic              fd_flush;
    cpu_pkg::word_t    redirect_pc;
    logic              wb_en;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    // redirect from execute and freeze from memory/writeback go back to fetch
    assign fd_if.flush       = fd_flush;
    assign fd_if.redirect_pc = redirect_pc;
    assign fd_if.freeze      = em_if.freeze;

    // writeback bundle for the register file
    assign wb_en   = em_if.wb_en;
    assign wb_rd   = em_if.wb_rd;
    assign wb_data = em_if.wb_data;

    cpu_fetch fetch_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fd        (fd_if.source)
    );

    cpu_decode decode_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .fd      (fd_if.sink),
        .de      (de_if.source),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    cpu_execute execute_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .de          (de_if.sink),
        .em          (em_if.source),
        .fd_flush    (fd_flush),
        .redirect_pc (redirect_pc)
    );

    cpu_mem_wb mem_wb_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .em           (em_if.sink),
        .io_in        (io_in),
        .io_out       (io_out),
        .io_out_valid (io_out_valid),
        .halted       (halted),
        .halt_pc      (halt_pc)
    );

endmodule

`default_nettype wire

//--- dv/cpu_properties.sv
// concurrent assertions on the cpu outputs, bound into every cpu_top instance
`timescale 1ns/100ps
`default_nettype none

module cpu_properties (
    input logic           clock,
    input logic           rst_n,
    input cpu_pkg::word_t imem_addr,
    input cpu_pkg::word_t io_out,
    input logic           io_out_valid,
    input logic           halted
);

    int violations = 0;

    // a halted core commits nothing and fetch stays on one address
    quiet_when_halted: assert property (
        @(posedge clock) disable iff (!rst_n)
            halted |-> !io_out_valid && (!$past(halted) || $stable(imem_addr))
    ) else begin
        violations++;
        $error("io_out_valid high or fetch address moving while halted");
    end

    // only reset clears halted
    halt_is_sticky: assert property (
        @(posedge clock) disable iff (!rst_n) !$fell(halted)
    ) else begin
        violations++;
        $error("halted fell without reset");
    end

    known_out_value: assert property (
        @(posedge clock) disable iff (!rst_n) io_out_valid |-> !$isunknown(io_out)
    ) else begin
        violations++;
        $error("io_out has unknown bits while valid");
    end

endmodule

bind cpu_top cpu_properties props_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .io_out       (io_out),
    .io_out_valid (io_out_valid),
    .halted       (halted)
);

`default_nettype wire

//--- dv/cpu_tb.sv
// testbench for cpu_top: runs random programs and checks outputs against a reference model
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    localparam int n_programs    = 40;
    localparam int n_random      = 30;
    localparam int prologue_len  = 32;
    localparam int prog_len      = prologue_len + n_random + 1;
    localparam int reset_cycles  = 10;
    localparam int settle_cycles = 5;
    localparam int margin        = 20;
    localparam int half_period   = 50;
    localparam int drive_delay   = 5;
    localparam int timeout_cycles = n_programs * (reset_cycles + 4 * prog_len + margin);
    localparam cpu_pkg::word_t halt_word = {cpu_pkg::op_halt, 12'h000};

    logic           clock;
    logic           rst_n;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_data;
    cpu_pkg::word_t io_in;
    cpu_pkg::word_t io_out;
    logic           io_out_valid;
    logic           halted;
    cpu_pkg::word_t halt_pc;

    cpu_pkg::word_t program_mem [256];
    cpu_pkg::word_t expected_out [$];
    cpu_pkg::word_t expected_halt_pc;
    integer         seed = 31355;

    cpu_top cpu_top_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .io_in        (io_in),
        .io_out       (io_out),
        .io_out_valid (io_out_valid),
        .halted       (halted),
        .halt_pc      (halt_pc)
    );

    initial clock = 1'b0;
    always #half_period clock = ~clock;

    // everything past the program reads as halt
    function automatic cpu_pkg::word_t instr_at(input cpu_pkg::word_t addr);
        if (addr < cpu_pkg::word_t'(prog_len)) begin
            return program_mem[addr[7:0]];
        end
        return halt_word;
    endfunction

    always_comb imem_data = instr_at(imem_addr);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input cpu_pkg::word_t got,
                                input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_pc(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_assertions();
        if (cpu_top_inst.props_inst.violations != 0) begin
            abort_run("a bound assertion on the cpu outputs failed");
        end
    endtask

    task automatic build_program();
        logic [7:0]        ptr;
        logic [3:0]        sel;
        logic [7:0]        offset;
        int                r;
        cpu_pkg::opcode_e  op;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t rs1;
        cpu_pkg::reg_idx_t rs2;
        ptr = '0;
        // words 0 to 15 each get a random value through r1
        for (int w = 0; w < 16; w++) begin
            r = $random(seed);
            program_mem[ptr] = {cpu_pkg::op_li, 4'd1, r[7:0]};
            ptr++;
            program_mem[ptr] = {cpu_pkg::op_sw, 4'd1, 4'd0, 4'(w)};
            ptr++;
        end
        for (int k = 0; k < n_random; k++) begin
            r      = $random(seed);
            rd     = {1'b0, r[2:0]};
            rs1    = {1'b0, r[5:3]};
            rs2    = {1'b0, r[8:6]};
            sel    = r[19:16];
            offset = 8'd1 + {6'b0, r[21:20]};
            // top selector codes all map to out, so results show often
            op = (sel > 4'd11) ? cpu_pkg::op_out : cpu_pkg::opcode_e'(sel);
            case (op)
                cpu_pkg::op_li:  program_mem[ptr] = {op, rd, r[31:24]};
                cpu_pkg::op_lw:  program_mem[ptr] = {op, rd, 4'd0, r[15:12]};
                cpu_pkg::op_sw:  program_mem[ptr] = {op, rd, 4'd0, r[15:12]};
                cpu_pkg::op_bz:  program_mem[ptr] = {op, rd, offset};
                cpu_pkg::op_jmp: program_mem[ptr] = {op, rd, offset};
                cpu_pkg::op_in:  program_mem[ptr] = {op, rd, 8'h00};
                cpu_pkg::op_out: program_mem[ptr] = {op, rd, 8'h00};
                default:         program_mem[ptr] = {op, rd, rs1, rs2};
            endcase
            ptr++;
        end
        program_mem[ptr] = halt_word;
    endtask

    // architectural model, one instruction per step with no pipeline
    task automatic run_model(input cpu_pkg::word_t in_value);
        cpu_pkg::word_t    regs [16];
        cpu_pkg::word_t    mem [256];
        cpu_pkg::word_t    pc;
        cpu_pkg::word_t    next_pc;
        cpu_pkg::word_t    ins;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    ea;
        cpu_pkg::word_t    offset;
        cpu_pkg::word_t    result;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::opcode_e  op;
        logic              done;
        int                steps;
        expected_out.delete();
        foreach (regs[i]) regs[i] = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            ins     = instr_at(pc);
            op      = cpu_pkg::opcode_e'(ins[15:12]);
            rd      = ins[11:8];
            a       = regs[ins[7:4]];
            b       = regs[ins[3:0]];
            ea      = a + {12'h000, ins[3:0]};
            offset  = {{8{ins[7]}}, ins[7:0]};
            result  = '0;
            next_pc = pc + 16'd1;
            case (op)
                cpu_pkg::op_add: result = a + b;
                cpu_pkg::op_sub: result = a - b;
                cpu_pkg::op_and: result = a & b;
                cpu_pkg::op_or:  result = a | b;
                cpu_pkg::op_xor: result = a ^ b;
                cpu_pkg::op_slt: result = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                cpu_pkg::op_li:  result = offset;
                cpu_pkg::op_lw:  result = mem[ea[7:0]];
                cpu_pkg::op_sw:  mem[ea[7:0]] = regs[rd];
                cpu_pkg::op_bz:  if (regs[rd] == '0) next_pc = pc + offset;
                cpu_pkg::op_jmp: next_pc = pc + offset;
                cpu_pkg::op_in:  result = in_value;
                cpu_pkg::op_out: expected_out.push_back(regs[rd]);
                cpu_pkg::op_halt: begin
                    expected_halt_pc = pc;
                    done = 1'b1;
                end
                default: ;
            endcase
            if (op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
                           cpu_pkg::op_xor, cpu_pkg::op_slt, cpu_pkg::op_li, cpu_pkg::op_lw,
                           cpu_pkg::op_in} && rd != '0) begin
                regs[rd] = result;
            end
            pc = next_pc;
            steps++;
            if (steps > 2 * prog_len) begin
                abort_run("reference model never reached a halt");
            end
        end
    endtask

    task automatic run_program();
        int r;
        @(posedge clock);
        #drive_delay;
        rst_n = 1'b0;
        r = $random(seed);
        io_in = r[15:0];
        build_program();
        run_model(io_in);
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        rst_n = 1'b1;
        // first instruction is still several cycles from commit
        @(negedge clock);
        check_flag("io_out_valid", io_out_valid, 1'b0);
        check_flag("halted", halted, 1'b0);
        compare_pc("imem_addr", imem_addr, '0);
        do begin
            @(negedge clock);
            check_assertions();
            if (io_out_valid) begin
                if (expected_out.size() == 0) begin
                    abort_run("io_out_valid pulsed while no out value was expected");
                end else begin
                    compare_word("io_out", io_out, expected_out.pop_front());
                end
            end
        end while (!halted);
        compare_pc("halt_pc", halt_pc, expected_halt_pc);
        if (expected_out.size() != 0) begin
            abort_run($sformatf("%0d expected out values never appeared", expected_out.size()));
        end
        repeat (settle_cycles) begin
            @(negedge clock);
            check_assertions();
            check_flag("halted", halted, 1'b1);
            check_flag("io_out_valid", io_out_valid, 1'b0);
        end
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        abort_run("watchdog expired before all programs finished, the run hung");
    end

    initial begin
        rst_n = 1'b0;
        io_in = '0;
        for (int p = 0; p < n_programs; p++) begin
            run_program();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := cpu_tb
FILELIST := tb.f
RUN_ARGS := +verilator+error+limit+100
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD)

//--- tb.f
hw/cpu_pkg.sv
hw/cpu_stage_ifs.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_mem_wb.sv
hw/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv
